/* ifu_aligner_pkg.sv */
/* shared widths and packets of the fetch aligner
   pc values drop bit 0, so all addressing is in 2-byte parcels */
`default_nettype none

package ifu_aligner_pkg;

   // ************************************************************
   // sizes
   // ************************************************************
   localparam int QUEUE_DEPTH = 3;            // fetch entries held by the aligner
   localparam int HALFWORD_W  = 16;           // rvc parcel

   typedef logic [31:1]             pc_t;     // parcel address
   typedef logic [2*HALFWORD_W-1:0] fetch_word_t;
   typedef logic [HALFWORD_W-1:0]   halfword_t;
   typedef logic [1:0]              hw_flags_t;   // one bit per parcel, right justified
   typedef logic [1:0]              fault_type_t;

   // ************************************************************
   // packets
   // ************************************************************

   // one fetch as delivered by fetch control
   typedef struct packed {
      fetch_word_t data;                      // memory format, lowest parcel at [15:0]
      pc_t         pc;                        // address of the lowest valid parcel
      hw_flags_t   val;
      hw_flags_t   icaf;
      fault_type_t icaf_type;
   } fetch_pkt_t;

   // one stage after rotation and offset, as the aligner sees it
   typedef struct packed {
      halfword_t   lo;
      halfword_t   hi;
      pc_t         pc;
      hw_flags_t   icaf;
      fault_type_t icaf_type;
   } stage_view_t;

   // instruction handed to decode
   typedef struct packed {
      logic        valid;
      fetch_word_t instr;                     // upper half zero for a 2-byte instruction
      halfword_t   cinst;                     // raw low parcel
      pc_t         pc;
      logic        pc4;                       // 4-byte instruction
      logic        icaf;
      fault_type_t icaf_type;
      logic        icaf_second;               // fault only on the second parcel
   } instr_pkt_t;

endpackage

`default_nettype wire

/* fetch_buffer_queue.sv */
/* three-entry store of fetch words, addressed by rotating pointers
   fetch control must not push while all entries are occupied; nothing here checks it */
`default_nettype none

module fetch_buffer_queue (
   input  logic                          clk,
   input  logic                          reset,
   input  ifu_aligner_pkg::fetch_pkt_t   fetch,
   input  logic                          flush,
   input  logic                          consume1,
   input  logic                          consume2,
   input  logic                          f0_shift_2b,
   input  logic                          f1_shift_2b,
   output ifu_aligner_pkg::stage_view_t  f0_view,
   output ifu_aligner_pkg::stage_view_t  f1_view
);
   import ifu_aligner_pkg::*;

   fetch_word_t            q_data [QUEUE_DEPTH];
   pc_t                    q_pc   [QUEUE_DEPTH];
   hw_flags_t              q_icaf [QUEUE_DEPTH];
   fault_type_t            q_type [QUEUE_DEPTH];
   logic [QUEUE_DEPTH-1:0] q_off;             // low parcel already consumed

   logic [1:0] wr_ptr, rd_ptr;
   logic [1:0] f0_idx, f1_idx;
   logic       wr_en;

   // step a pointer around the three entries
   function automatic logic [1:0] ptr_add(input logic [1:0] ptr, input logic [1:0] step);
      logic [2:0] sum;
      sum = 3'(ptr) + 3'(step);
      if (sum >= 3'(QUEUE_DEPTH))
         sum = sum - 3'(QUEUE_DEPTH);
      return sum[1:0];
   endfunction

   // upper parcel moves down once the lower one is gone
   function automatic stage_view_t make_view(input fetch_word_t data, input pc_t pc,
                                             input hw_flags_t icaf, input fault_type_t ftype,
                                             input logic off);
      stage_view_t v;
      v.lo        = off ? data[2*HALFWORD_W-1:HALFWORD_W] : data[HALFWORD_W-1:0];
      v.hi        = off ? '0 : data[2*HALFWORD_W-1:HALFWORD_W];
      v.pc        = off ? pc + 31'd1 : pc;
      v.icaf      = off ? {1'b0, icaf[1]} : icaf;
      v.icaf_type = ftype;
      return v;
   endfunction

   assign wr_en  = fetch.val[0] & ~flush;     // fetch in a flush cycle is dropped
   assign f0_idx = rd_ptr;
   assign f1_idx = ptr_add(rd_ptr, 2'd1);

   // ************************************************************
   // pointers and offsets
   // ************************************************************
   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= ptr_add(wr_ptr, 2'd1);
         if (consume2)
            rd_ptr <= ptr_add(rd_ptr, 2'd2);
         else if (consume1)
            rd_ptr <= ptr_add(rd_ptr, 2'd1);
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         q_off <= '0;
      end else begin
         for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (wr_en && wr_ptr == 2'(i))
               q_off[i] <= 1'b0;                          // fresh fetch starts at parcel 0
            else if (f0_idx == 2'(i))
               q_off[i] <= q_off[i] | f0_shift_2b;
            else if (f1_idx == 2'(i))
               q_off[i] <= q_off[i] | f1_shift_2b;        // second half of a straddling 4B
         end
      end
   end

   // ************************************************************
   // payload
   // ************************************************************
   always_ff @(posedge clk) begin
      if (wr_en) begin
         q_data[wr_ptr] <= fetch.data;
         q_pc[wr_ptr]   <= fetch.pc;
         q_icaf[wr_ptr] <= fetch.icaf;
         q_type[wr_ptr] <= fetch.icaf_type;
      end
   end

   // the two oldest entries, rotated by the read pointer
   assign f0_view = make_view(q_data[f0_idx], q_pc[f0_idx], q_icaf[f0_idx],
                              q_type[f0_idx], q_off[f0_idx]);
   assign f1_view = make_view(q_data[f1_idx], q_pc[f1_idx], q_icaf[f1_idx],
                              q_type[f1_idx], q_off[f1_idx]);

endmodule

`default_nettype wire

/* buffer_valid_ctl.sv */
/* parcel valids of the logical stages f0 (oldest), f1 and f2
   a fetch must not be offered while all three stages hold data */
`default_nettype none

module buffer_valid_ctl (
   input  logic                        clk,
   input  logic                        reset,
   input  ifu_aligner_pkg::hw_flags_t  fetch_val,
   input  logic                        flush,
   input  logic                        shift_2b,
   input  logic                        shift_4b,
   output ifu_aligner_pkg::hw_flags_t  f0_val,
   output ifu_aligner_pkg::hw_flags_t  f1_val,
   output logic                        f0_shift_2b,
   output logic                        f1_shift_2b,
   output logic                        consume1,
   output logic                        consume2
);
   import ifu_aligner_pkg::*;

   hw_flags_t f0val, f1val, f2val;            // registered stage valids
   hw_flags_t sf0val, sf1val;                 // after this cycle's shift
   hw_flags_t f0_nxt, f1_nxt, f2_nxt;
   hw_flags_t fetch_in;
   logic      consume_f0, consume_f1;

   assign fetch_in = fetch_val[0] ? fetch_val : 2'b00;

   // parcels leaving f0 and f1
   assign f0_shift_2b = (shift_2b & f0val[0]) |
                        (shift_4b & f0val[0] & ~f0val[1]);
   assign f1_shift_2b = shift_4b & f0val[0] & ~f0val[1];   // 4B spans f0 and f1

   assign sf0val = shift_4b ? 2'b00 :
                   shift_2b ? {1'b0, f0val[1]} : f0val;
   assign sf1val = f1_shift_2b ? {1'b0, f1val[1]} : f1val;

   // a stage that just lost its last parcel frees its entry
   assign consume_f0 = f0val[0] & ~sf0val[0];
   assign consume_f1 = f1val[0] & ~sf1val[0];
   assign consume1   = consume_f0 & ~consume_f1 & ~flush;
   assign consume2   = consume_f0 &  consume_f1 & ~flush;

   // ************************************************************
   // compaction and fill, keyed on {sf0, sf1, f2} occupancy
   // ************************************************************
   always_comb begin
      f0_nxt = sf0val;
      f1_nxt = sf1val;
      f2_nxt = f2val;
      case ({sf0val[0], sf1val[0], f2val[0]})
         3'b000: f0_nxt = fetch_in;
         3'b100: f1_nxt = fetch_in;
         3'b010: begin
            f0_nxt = sf1val;
            f1_nxt = fetch_in;
         end
         3'b110: f2_nxt = fetch_in;
         3'b001: begin                        // f0 and f1 drained together
            f0_nxt = f2val;
            f1_nxt = fetch_in;
            f2_nxt = 2'b00;
         end
         3'b011: begin
            f0_nxt = sf1val;
            f1_nxt = f2val;
            f2_nxt = fetch_in;
         end
         default: ;                           // 111 full, 101 cannot occur
      endcase
      if (flush) begin
         f0_nxt = 2'b00;
         f1_nxt = 2'b00;
         f2_nxt = 2'b00;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         f0val <= '0;
         f1val <= '0;
         f2val <= '0;
      end else begin
         f0val <= f0_nxt;
         f1val <= f1_nxt;
         f2val <= f2_nxt;
      end
   end

   assign f0_val = f0val;
   assign f1_val = f1val;

endmodule

`default_nettype wire

/* instr_align.sv */
/* builds the next instruction from the two oldest stages, purely combinational
   compressed instructions leave unexpanded on cinst */
`default_nettype none

module instr_align (
   input  ifu_aligner_pkg::stage_view_t  f0_view,
   input  ifu_aligner_pkg::stage_view_t  f1_view,
   input  ifu_aligner_pkg::hw_flags_t    f0_val,
   input  ifu_aligner_pkg::hw_flags_t    f1_val,
   input  logic                          decode_accept,
   output ifu_aligner_pkg::instr_pkt_t   i0,
   output logic                          shift_2b,
   output logic                          shift_4b,
   output logic                          instr_aligned
);
   import ifu_aligner_pkg::*;

   fetch_word_t align_data;
   hw_flags_t   align_val;
   hw_flags_t   align_icaf;
   logic        f0_full;                      // both parcels of f0 present
   logic        first4b;
   logic        i0_valid;
   logic        i0_shift;

   assign f0_full = f0_val[1];

   // ************************************************************
   // parcel selection
   // ************************************************************
   // second parcel from f0 when it has two, otherwise from f1
   assign align_data = f0_full ? {f0_view.hi, f0_view.lo} : {f1_view.lo, f0_view.lo};
   assign align_val  = f0_full ? 2'b11 : {f1_val[0] & f0_val[0], f0_val[0]};
   assign align_icaf = f0_full ? f0_view.icaf : {f1_view.icaf[0], f0_view.icaf[0]};

   assign first4b  = (align_data[1:0] == 2'b11);
   assign i0_valid = first4b ? align_val[1] : align_val[0];

   // ************************************************************
   // outgoing packet
   // ************************************************************
   always_comb begin
      i0.valid = i0_valid;
      if (i0_valid && first4b)
         i0.instr = align_data;
      else if (i0_valid)
         i0.instr = {{HALFWORD_W{1'b0}}, align_data[HALFWORD_W-1:0]};
      else
         i0.instr = '0;
      i0.cinst = align_data[HALFWORD_W-1:0];
      i0.pc    = f0_view.pc;
      i0.pc4   = first4b;
      // any faulted parcel of the instruction faults it
      i0.icaf  = first4b ? |align_icaf : align_icaf[0];
      i0.icaf_second = first4b & ~align_icaf[0] & align_icaf[1];
      if (first4b && !f0_full && !align_icaf[0])
         i0.icaf_type = f1_view.icaf_type;    // fault came from the f1 half
      else
         i0.icaf_type = f0_view.icaf_type;
   end

   // accepted this cycle
   assign i0_shift      = decode_accept & i0_valid;
   assign instr_aligned = i0_shift;
   assign shift_2b      = i0_shift & ~first4b;
   assign shift_4b      = i0_shift &  first4b;

endmodule

`default_nettype wire

/* ifu_aligner.sv */
/* instruction aligner top: fetch buffer, valid control and align logic
   decode accepts in the same cycle; no back-pressure toward fetch */
`default_nettype none

module ifu_aligner (
   input  logic                         clk,
   input  logic                         reset,
   input  ifu_aligner_pkg::fetch_pkt_t  fetch,
   input  logic                         flush,
   input  logic                         decode_accept,
   output ifu_aligner_pkg::instr_pkt_t  i0,
   output logic                         consume1,
   output logic                         consume2,
   output logic                         instr_aligned
);
   import ifu_aligner_pkg::*;

   stage_view_t f0_view, f1_view;
   hw_flags_t   f0_val, f1_val;
   logic        f0_shift_2b, f1_shift_2b;
   logic        shift_2b, shift_4b;

   fetch_buffer_queue u_queue (
      .clk         (clk),
      .reset       (reset),
      .fetch       (fetch),
      .flush       (flush),
      .consume1    (consume1),
      .consume2    (consume2),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .f0_view     (f0_view),
      .f1_view     (f1_view)
   );

   buffer_valid_ctl u_valid_ctl (
      .clk         (clk),
      .reset       (reset),
      .fetch_val   (fetch.val),
      .flush       (flush),
      .shift_2b    (shift_2b),
      .shift_4b    (shift_4b),
      .f0_val      (f0_val),
      .f1_val      (f1_val),
      .f0_shift_2b (f0_shift_2b),
      .f1_shift_2b (f1_shift_2b),
      .consume1    (consume1),
      .consume2    (consume2)
   );

   instr_align u_align (
      .f0_view       (f0_view),
      .f1_view       (f1_view),
      .f0_val        (f0_val),
      .f1_val        (f1_val),
      .decode_accept (decode_accept),
      .i0            (i0),
      .shift_2b      (shift_2b),
      .shift_4b      (shift_4b),
      .instr_aligned (instr_aligned)
   );

endmodule

`default_nettype wire

/* ifu_aligner_properties.sv */
/* protocol assertions on the aligner top level, attached by bind
   all checks are disabled while reset is high */
`default_nettype none

module ifu_aligner_properties (
   input logic                        clk,
   input logic                        reset,
   input logic                        flush,
   input logic                        decode_accept,
   input ifu_aligner_pkg::instr_pkt_t i0,
   input logic                        consume1,
   input logic                        consume2
);
   import ifu_aligner_pkg::*;

   // at most one consume flavor per cycle
   consume_onehot: assert property (@(posedge clk) disable iff (reset)
      !(consume1 && consume2)) else $error("consume1 and consume2 both high");

   consume_quiet_on_flush: assert property (@(posedge clk) disable iff (reset)
      flush |-> (!consume1 && !consume2)) else $error("consume during flush");

   // decode stall holds the packet
   i0_hold: assert property (@(posedge clk) disable iff (reset)
      (i0.valid && !decode_accept && !flush) |=> $stable(i0)) else $error("i0 moved while stalled");

   flush_clears: assert property (@(posedge clk) disable iff (reset)
      flush |=> !i0.valid) else $error("i0 valid right after flush");

endmodule

`default_nettype wire

/* ifu_aligner_checker.sv */
/* halfword reference model of the aligner, sampled on the rising edge
   a flush empties the model, and a fetch offered in that cycle is dropped */
`default_nettype none

module ifu_aligner_checker (
   input  logic                        clk,
   input  logic                        reset,
   input  ifu_aligner_pkg::fetch_pkt_t fetch,
   input  logic                        flush,
   input  logic                        decode_accept,
   input  ifu_aligner_pkg::instr_pkt_t i0,
   input  logic                        consume1,
   input  logic                        consume2,
   input  logic                        instr_aligned,
   input  int                          test_id,
   input  logic                        test_end,
   output int                          errors,
   output int                          checks
);
   import ifu_aligner_pkg::*;

   halfword_t   q_hw [$];                     // model queue, one entry per parcel
   pc_t         q_pc [$];
   logic        q_fault [$];
   fault_type_t q_type [$];
   logic        q_last [$];                   // last parcel of its fetch

   int        pushed, consumed, exp_cons, test_errors;
   logic      exp_valid, is4b, in_reset;
   halfword_t h0, h1;
   logic      f0, f1;

   function automatic string test_name(input int id);
      case (id)
         0: return "reset";
         1: return "random_stream";
         2: return "straddle";
         3: return "access_faults";
         4: return "flush";
         default: return "unknown";
      endcase
   endfunction

   task automatic check_value(input string field, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("error %s %s: expected %h, actual %h", test_name(test_id), field, exp, act);
      end
   endtask

   task automatic clear_model();
      q_hw.delete();
      q_pc.delete();
      q_fault.delete();
      q_type.delete();
      q_last.delete();
      pushed   = 0;
      consumed = 0;
   endtask

   task automatic push_parcel(input halfword_t h, input pc_t pc, input logic f,
                              input fault_type_t t, input logic last);
      q_hw.push_back(h);
      q_pc.push_back(pc);
      q_fault.push_back(f);
      q_type.push_back(t);
      q_last.push_back(last);
   endtask

   task automatic pop_parcel();
      exp_cons += int'(q_last[0]);
      void'(q_hw.pop_front());
      void'(q_pc.pop_front());
      void'(q_fault.pop_front());
      void'(q_type.pop_front());
      void'(q_last.pop_front());
   endtask

   initial begin
      errors = 0;
      checks = 0;
      test_errors = 0;
      in_reset = 1'b0;
      clear_model();
   end

   // ************************************************************
   // per-cycle compare
   // ************************************************************
   always @(posedge clk) begin
      if (reset) begin
         if (in_reset) begin                  // registers settled after first reset edge
            check_value("reset i0.valid", 32'(1'b0), 32'(i0.valid));
            check_value("reset consume", 32'(2'b00), 32'({consume1, consume2}));
            check_value("reset instr_aligned", 32'(1'b0), 32'(instr_aligned));
         end
         in_reset = 1'b1;
         clear_model();
      end else begin
         in_reset  = 1'b0;
         exp_cons  = 0;
         is4b      = (q_hw.size() > 0) && (q_hw[0][1:0] == 2'b11);
         exp_valid = (q_hw.size() > 0) && (!is4b || q_hw.size() > 1);
         check_value("i0.valid", 32'(exp_valid), 32'(i0.valid));
         check_value("instr_aligned", 32'(decode_accept && exp_valid), 32'(instr_aligned));
         if (flush) begin
            check_value("flush consume", 32'(2'b00), 32'({consume1, consume2}));
            clear_model();                    // fetch in this cycle is dropped too
         end else begin
            if (decode_accept && i0.valid && exp_valid) begin
               h0 = q_hw[0];
               f0 = q_fault[0];
               h1 = is4b ? q_hw[1] : '0;
               f1 = is4b ? q_fault[1] : 1'b0;
               check_value("instr", is4b ? {h1, h0} : {16'h0, h0}, i0.instr);
               check_value("cinst", 32'(h0), 32'(i0.cinst));
               check_value("pc", 32'(q_pc[0]), 32'(i0.pc));
               check_value("pc4", 32'(is4b), 32'(i0.pc4));
               check_value("icaf", 32'(f0 | f1), 32'(i0.icaf));
               check_value("icaf_second", 32'(!f0 && f1), 32'(i0.icaf_second));
               check_value("icaf_type", 32'((is4b && !f0) ? q_type[1] : q_type[0]),
                           32'(i0.icaf_type));
               pop_parcel();
               if (is4b)
                  pop_parcel();
            end
            check_value("consume", 32'(exp_cons), 32'(int'(consume1) + 2 * int'(consume2)));
            consumed += int'(consume1) + 2 * int'(consume2);
            if (fetch.val[0]) begin
               push_parcel(fetch.data[15:0], fetch.pc, fetch.icaf[0], fetch.icaf_type,
                           !fetch.val[1]);
               if (fetch.val[1])
                  push_parcel(fetch.data[31:16], fetch.pc + 31'd1, fetch.icaf[1],
                              fetch.icaf_type, 1'b1);
               pushed++;
            end
         end
      end
      if (test_end) begin
         if (q_hw.size() != 0) begin
            errors++;
            $display("test %s ended with %0d parcels never accepted",
                     test_name(test_id), q_hw.size());
         end
         check_value("buffer balance", 32'(pushed), 32'(consumed));
         $display("test %s: %s (%0d errors)", test_name(test_id),
                  (errors == test_errors) ? "ok" : "failed", errors - test_errors);
         test_errors = errors;
      end
   end

endmodule

`default_nettype wire

/* tb_ifu_aligner.sv */
/* random fetch stream into the aligner, checked by ifu_aligner_checker
   fetch control here never offers a fetch while three entries are held */
`default_nettype none

module tb_ifu_aligner;
   import ifu_aligner_pkg::*;

   localparam logic [31:0] SEED = 32'h28356ad5;
   localparam int N_STREAM = 400;
   localparam int N_STRADDLE = 300;
   localparam int N_FAULT = 300;
   localparam int N_FLUSH = 400;
   localparam int CYCLE_LIMIT = 16 * (N_STREAM + N_STRADDLE + N_FAULT + N_FLUSH) + 1000;

   logic        clk = 1'b0;
   logic        reset, flush, decode_accept, test_end;
   fetch_pkt_t  fetch;
   instr_pkt_t  i0;
   logic        consume1, consume2, instr_aligned;
   int          test_id, errors, checks, occ, cycles;
   logic [31:0] lfsr_state;
   logic        pending;                      // second half of a 4B still owed
   pc_t         next_pc;

   always #10 clk = ~clk;

   ifu_aligner DUT (
      .clk(clk), .reset(reset), .fetch(fetch), .flush(flush),
      .decode_accept(decode_accept), .i0(i0), .consume1(consume1),
      .consume2(consume2), .instr_aligned(instr_aligned)
   );

   bind ifu_aligner ifu_aligner_properties props (
      .clk(clk), .reset(reset), .flush(flush), .decode_accept(decode_accept),
      .i0(i0), .consume1(consume1), .consume2(consume2)
   );

   ifu_aligner_checker check (
      .clk(clk), .reset(reset), .fetch(fetch), .flush(flush),
      .decode_accept(decode_accept), .i0(i0), .consume1(consume1),
      .consume2(consume2), .instr_aligned(instr_aligned), .test_id(test_id),
      .test_end(test_end), .errors(errors), .checks(checks)
   );

   // entries held, as fetch control would count them
   always @(posedge clk) begin
      if (reset || flush)
         occ <= 0;
      else
         occ <= occ + int'(fetch.val[0]) - int'(consume1) - 2 * int'(consume2);
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < nbits; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic next_halfword(output halfword_t h);
      logic [1:0] lo;
      if (pending) begin
         pending = 1'b0;
         h = halfword_t'(lfsr_take(16));
      end else if (lfsr_take(1) == 1) begin
         pending = 1'b1;
         h = {14'(lfsr_take(14)), 2'b11};
      end else begin
         lo = 2'(lfsr_take(2));
         h = {14'(lfsr_take(14)), (lo == 2'b11) ? 2'b01 : lo};
      end
   endtask

   task automatic build_fetch(input logic straddle, input logic faults);
      int        cnt;
      halfword_t h0, h1;
      logic      fa0, fa1;
      if (straddle)
         cnt = (lfsr_take(2) == 0) ? 2 : 1;   // mostly single parcels
      else
         cnt = (lfsr_take(2) == 0) ? 1 : 2;
      next_halfword(h0);
      if (cnt == 2)
         next_halfword(h1);
      else
         h1 = halfword_t'(lfsr_take(16));     // junk above a single parcel
      if (lfsr_take(4) == 0)
         next_pc = pc_t'(lfsr_take(31));      // taken-branch style jump
      fa0 = faults && (lfsr_take(3) == 0);
      fa1 = faults && (cnt == 2) && (lfsr_take(3) == 0);
      fetch.data      = {h1, h0};
      fetch.pc        = next_pc;
      fetch.val       = (cnt == 2) ? 2'b11 : 2'b01;
      fetch.icaf      = {fa1, fa0};
      fetch.icaf_type = fault_type_t'(lfsr_take(2));
      next_pc = next_pc + pc_t'(cnt);
   endtask

   task automatic run_stream(input int n, input logic straddle, input logic faults,
                             input logic flushes);
      int sent;
      sent = 0;
      while (sent < n || pending) begin
         fetch = '0;
         flush = 1'b0;
         decode_accept = (lfsr_take(2) != 0);
         if (flushes && lfsr_take(6) == 0) begin
            flush = 1'b1;
            pending = 1'b0;                   // stream restarts after flush
            next_pc = pc_t'(lfsr_take(31));
            if (lfsr_take(1) == 1) begin      // offered but must be dropped
               fetch.data = lfsr_take(32);
               fetch.pc   = pc_t'(lfsr_take(31));
               fetch.val  = 2'b11;
            end
         end else if (occ < QUEUE_DEPTH && lfsr_take(1) == 1) begin
            build_fetch(straddle, faults);
            sent++;
         end
         @(negedge clk);
      end
      // drain everything still buffered
      fetch = '0;
      flush = 1'b0;
      decode_accept = 1'b1;
      while (occ != 0)
         @(negedge clk);
      decode_accept = 1'b0;
   endtask

   task automatic finish_test();
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
   endtask

   // ************************************************************
   // test sequence
   // ************************************************************
   initial begin
      lfsr_state = SEED;
      reset = 1'b1;
      flush = 1'b0;
      decode_accept = 1'b0;
      test_end = 1'b0;
      fetch = '0;
      test_id = 0;
      cycles = 0;
      pending = 1'b0;
      next_pc = pc_t'(31'h0000_1000);
      repeat (2) @(negedge clk);
      reset = 1'b0;
      repeat (4) @(negedge clk);
      finish_test();
      test_id = 1;
      run_stream(N_STREAM, 1'b0, 1'b0, 1'b0);
      finish_test();
      test_id = 2;
      run_stream(N_STRADDLE, 1'b1, 1'b0, 1'b0);
      finish_test();
      test_id = 3;
      run_stream(N_FAULT, 1'b0, 1'b1, 1'b0);
      finish_test();
      test_id = 4;
      run_stream(N_FLUSH, 1'b0, 1'b1, 1'b1);
      finish_test();
      $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

/* ifu_aligner.f */
ifu_aligner_pkg.sv
fetch_buffer_queue.sv
buffer_valid_ctl.sv
instr_align.sv
ifu_aligner.sv
ifu_aligner_properties.sv
ifu_aligner_checker.sv
tb_ifu_aligner.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       ?= tb_ifu_aligner
FLIST     ?= ifu_aligner.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
